//--- build.f
+incdir+common
common/backend_pkg.sv
design/phys_regfile.sv
design/alu_unit.sv
design/mult_unit.sv
design/cdb_arbiter.sv
design/exec_backend.sv
testbench/backend_chk.sv
testbench/backend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f build.f \
    --top-module backend_tb \
    -o backend_sim

./obj_dir/backend_sim | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"

//--- testbench/backend_tb.sv
`include "backend_defines.svh"

module backend_tb;

    localparam int N_ENTRIES = 27;
    localparam int LIMIT     = N_ENTRIES * 10 + 100;

    localparam logic [1:0] U_ALU0 = 2'd0;
    localparam logic [1:0] U_ALU1 = 2'd1;
    localparam logic [1:0] U_MULT = 2'd2;

    typedef struct packed {
        logic [1:0]             unit;
        backend_pkg::alu_op_t   op;
        backend_pkg::phys_tag_t src1;
        backend_pkg::phys_tag_t src2;
        backend_pkg::phys_tag_t dest;
    } entry_t;

    // Back-to-back sources on the same ALU exercise CDB forwarding
    entry_t stim [N_ENTRIES] = '{
        '{U_ALU0, backend_pkg::ALU_LI,  5'd0,  5'd0,  5'd1},
        '{U_ALU1, backend_pkg::ALU_LI,  5'd0,  5'd0,  5'd2},
        '{U_ALU0, backend_pkg::ALU_LI,  5'd0,  5'd0,  5'd3},
        '{U_ALU1, backend_pkg::ALU_LI,  5'd0,  5'd0,  5'd4},
        '{U_ALU0, backend_pkg::ALU_ADD, 5'd1,  5'd2,  5'd5},
        '{U_ALU0, backend_pkg::ALU_SUB, 5'd5,  5'd3,  5'd6},
        '{U_ALU1, backend_pkg::ALU_AND, 5'd1,  5'd4,  5'd7},
        '{U_ALU1, backend_pkg::ALU_OR,  5'd7,  5'd2,  5'd8},
        '{U_ALU0, backend_pkg::ALU_XOR, 5'd6,  5'd8,  5'd9},
        '{U_ALU1, backend_pkg::ALU_SLL, 5'd9,  5'd3,  5'd10},
        '{U_MULT, backend_pkg::ALU_ADD, 5'd1,  5'd2,  5'd11},
        '{U_MULT, backend_pkg::ALU_ADD, 5'd3,  5'd4,  5'd12},
        '{U_MULT, backend_pkg::ALU_ADD, 5'd5,  5'd6,  5'd13},
        '{U_ALU0, backend_pkg::ALU_ADD, 5'd7,  5'd8,  5'd14},
        '{U_ALU1, backend_pkg::ALU_SUB, 5'd9,  5'd10, 5'd15},
        '{U_MULT, backend_pkg::ALU_ADD, 5'd11, 5'd12, 5'd16},
        '{U_ALU0, backend_pkg::ALU_LI,  5'd0,  5'd0,  5'd0},
        '{U_ALU1, backend_pkg::ALU_ADD, 5'd0,  5'd1,  5'd17},
        '{U_MULT, backend_pkg::ALU_ADD, 5'd0,  5'd13, 5'd18},
        '{U_ALU0, backend_pkg::ALU_ADD, 5'd14, 5'd15, 5'd19},
        '{U_ALU1, backend_pkg::ALU_XOR, 5'd16, 5'd17, 5'd20},
        '{U_MULT, backend_pkg::ALU_ADD, 5'd2,  5'd3,  5'd21},
        '{U_ALU0, backend_pkg::ALU_LI,  5'd0,  5'd0,  5'd22},
        '{U_ALU1, backend_pkg::ALU_LI,  5'd0,  5'd0,  5'd23},
        '{U_MULT, backend_pkg::ALU_ADD, 5'd22, 5'd23, 5'd24},
        '{U_ALU0, backend_pkg::ALU_SLL, 5'd24, 5'd22, 5'd25},
        '{U_ALU0, backend_pkg::ALU_OR,  5'd25, 5'd0,  5'd26}
    };

    logic                   clock;
    logic                   reset;
    logic                   alu_valid [`NUM_FU_ALU];
    backend_pkg::alu_op_t   alu_op    [`NUM_FU_ALU];
    backend_pkg::phys_tag_t alu_src1  [`NUM_FU_ALU];
    backend_pkg::phys_tag_t alu_src2  [`NUM_FU_ALU];
    backend_pkg::phys_tag_t alu_dest  [`NUM_FU_ALU];
    backend_pkg::data_t     alu_imm   [`NUM_FU_ALU];
    logic                   alu_ready [`NUM_FU_ALU];
    logic                   mult_valid;
    backend_pkg::phys_tag_t mult_src1;
    backend_pkg::phys_tag_t mult_src2;
    backend_pkg::phys_tag_t mult_dest;
    logic                   mult_ready;
    logic                   cdb_valid [`CDB_SZ];
    backend_pkg::phys_tag_t cdb_tag   [`CDB_SZ];
    backend_pkg::data_t     cdb_data  [`CDB_SZ];

    // Register values as seen by readers, and the data each tag broadcasts
    backend_pkg::data_t model     [`PHYS_REG_SZ];
    backend_pkg::data_t expect_bc [`PHYS_REG_SZ];
    logic               issued    [`PHYS_REG_SZ];
    logic               seen      [`PHYS_REG_SZ];

    int          pend          [`NUM_FU];
    logic        accepted      [`NUM_FU];
    int          last_alu_dest [`NUM_FU_ALU];
    int          head;
    int          seen_count;
    int          errors;
    int          cycles;
    logic [31:0] rng;

    exec_backend dut0 (
        .clock(clock), .reset(reset),
        .alu_valid(alu_valid), .alu_op(alu_op), .alu_src1(alu_src1),
        .alu_src2(alu_src2), .alu_dest(alu_dest), .alu_imm(alu_imm),
        .alu_ready(alu_ready),
        .mult_valid(mult_valid), .mult_src1(mult_src1), .mult_src2(mult_src2),
        .mult_dest(mult_dest), .mult_ready(mult_ready),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic backend_pkg::data_t expected_value(input entry_t e,
            input backend_pkg::data_t a, input backend_pkg::data_t b,
            input backend_pkg::data_t imm);
        if (e.unit == U_MULT) begin
            return a * b;
        end
        case (e.op)
            backend_pkg::ALU_ADD: return a + b;
            backend_pkg::ALU_SUB: return a - b;
            backend_pkg::ALU_AND: return a & b;
            backend_pkg::ALU_OR:  return a | b;
            backend_pkg::ALU_XOR: return a ^ b;
            backend_pkg::ALU_SLL: return a << b[4:0];
            backend_pkg::ALU_LI:  return imm;
            default:              return '0;
        endcase
    endfunction

    function automatic logic src_ready(input backend_pkg::phys_tag_t t, input logic [1:0] u);
        if (t == '0 || seen[t]) begin
            return 1'b1;
        end
        // Held in this ALU, so it is on the CDB in the cycle the ALU takes the next entry
        if (u != U_MULT && last_alu_dest[u[0]] == int'(t)) begin
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic issue_step();
        entry_t             e;
        backend_pkg::data_t imm;
        logic               stop;
        for (int u = 0; u < `NUM_FU; u++) begin
            if (accepted[u]) begin
                if (u < `NUM_FU_ALU) begin
                    last_alu_dest[u] = int'(stim[pend[u]].dest);
                end
                pend[u] = -1;
            end
        end
        rng  = xorshift(rng);
        stop = (rng[2:0] == 3'd0);
        while (!stop && head < N_ENTRIES) begin
            e = stim[head];
            if (pend[e.unit] >= 0 || !src_ready(e.src1, e.unit) || !src_ready(e.src2, e.unit)) begin
                stop = 1'b1;
            end else begin
                rng = xorshift(rng);
                imm = rng;
                expect_bc[e.dest] = expected_value(e, model[e.src1], model[e.src2], imm);
                if (e.dest != '0) begin
                    model[e.dest] = expect_bc[e.dest];
                end
                issued[e.dest] = 1'b1;
                pend[e.unit]   = head;
                if (e.unit == U_MULT) begin
                    mult_valid <= 1'b1;
                    mult_src1  <= e.src1;
                    mult_src2  <= e.src2;
                    mult_dest  <= e.dest;
                end else begin
                    alu_valid[e.unit[0]] <= 1'b1;
                    alu_op[e.unit[0]]    <= e.op;
                    alu_src1[e.unit[0]]  <= e.src1;
                    alu_src2[e.unit[0]]  <= e.src2;
                    alu_dest[e.unit[0]]  <= e.dest;
                    alu_imm[e.unit[0]]   <= imm;
                end
                head++;
            end
        end
        for (int u = 0; u < `NUM_FU_ALU; u++) begin
            if (pend[u] < 0) begin
                alu_valid[u] <= 1'b0;
            end
        end
        if (pend[U_MULT] < 0) begin
            mult_valid <= 1'b0;
        end
    endtask

    task automatic check_broadcast(input int s);
        backend_pkg::phys_tag_t t;
        t = cdb_tag[s];
        assert (issued[t] && !seen[t]) else begin
            $display("Tag %0d was broadcast twice or without being issued", t);
            errors++;
        end
        assert (cdb_data[s] === expect_bc[t]) else begin
            $display("** Error: cdb_data[%0d] tag %h expected %h got %h",
                     s, t, expect_bc[t], cdb_data[s]);
            errors++;
        end
        if (!seen[t]) begin
            seen_count++;
        end
        seen[t] = 1'b1;
    endtask

    // Mid-cycle sampling of handshakes and the CDB
    always @(negedge clock) begin
        if (!reset) begin
            for (int u = 0; u < `NUM_FU_ALU; u++) begin
                accepted[u] = alu_valid[u] && alu_ready[u];
            end
            accepted[U_MULT] = mult_valid && mult_ready;
            for (int s = 0; s < `CDB_SZ; s++) begin
                if (cdb_valid[s]) begin
                    check_broadcast(s);
                end
            end
        end
    end

    initial begin
        rng        = 32'hb6db;
        head       = 0;
        seen_count = 0;
        errors     = 0;
        cycles     = 0;
        reset      <= 1'b1;
        mult_valid <= 1'b0;
        mult_src1  <= '0;
        mult_src2  <= '0;
        mult_dest  <= '0;
        for (int u = 0; u < `NUM_FU_ALU; u++) begin
            alu_valid[u]     <= 1'b0;
            alu_op[u]        <= backend_pkg::ALU_ADD;
            alu_src1[u]      <= '0;
            alu_src2[u]      <= '0;
            alu_dest[u]      <= '0;
            alu_imm[u]       <= '0;
            last_alu_dest[u] = -1;
        end
        for (int u = 0; u < `NUM_FU; u++) begin
            pend[u]     = -1;
            accepted[u] = 1'b0;
        end
        for (int t = 0; t < `PHYS_REG_SZ; t++) begin
            model[t]     = '0;
            expect_bc[t] = '0;
            issued[t]    = 1'b0;
            seen[t]      = 1'b0;
        end
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        while (seen_count < N_ENTRIES && cycles < LIMIT) begin
            @(posedge clock);
            cycles++;
            issue_step();
        end
        assert (seen_count == N_ENTRIES) else begin
            $display("Timeout after %0d cycles, %0d of %0d broadcasts still missing",
                     cycles, N_ENTRIES - seen_count, N_ENTRIES);
            errors++;
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- testbench/backend_chk.sv
`include "backend_defines.svh"

module backend_chk (
    input logic                   clock,
    input logic                   reset,
    input backend_pkg::fu_mask_t  req,
    input backend_pkg::fu_mask_t  grant,
    input logic                   slot_valid [`CDB_SZ],
    input backend_pkg::fu_idx_t   slot_owner [`CDB_SZ],
    input logic                   cdb_valid  [`CDB_SZ],
    input backend_pkg::phys_tag_t cdb_tag    [`CDB_SZ]
);

    // Arbiter never grants an idle unit
    grant_needs_req: assert property (@(posedge clock) disable iff (reset)
        (grant & ~req) == '0)
        else $error("CDB grant without a request");

    for (genvar i = 0; i < `CDB_SZ; i++) begin : g_slot
        // Bus is quiet in the first cycle out of reset
        quiet_after_reset: assert property (@(posedge clock) reset |=> !cdb_valid[i])
            else $error("CDB slot %0d valid right after reset", i);

        for (genvar j = i + 1; j < `CDB_SZ; j++) begin : g_pair
            owner_unique: assert property (@(posedge clock) disable iff (reset)
                (slot_valid[i] && slot_valid[j]) |-> (slot_owner[i] != slot_owner[j]))
                else $error("CDB slots %0d and %0d share an owner", i, j);

            tag_unique: assert property (@(posedge clock) disable iff (reset)
                (cdb_valid[i] && cdb_valid[j]) |-> (cdb_tag[i] != cdb_tag[j]))
                else $error("CDB slots %0d and %0d carry the same tag", i, j);
        end
    end

endmodule

bind exec_backend backend_chk chk0 (
    .clock(clock), .reset(reset),
    .req(fu_req), .grant(fu_grant),
    .slot_valid(slot_valid), .slot_owner(slot_owner),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag)
);

//--- design/exec_backend.sv
`include "backend_defines.svh"

module exec_backend (
    input  logic                   clock,
    input  logic                   reset,

    // ALU issue
    input  logic                   alu_valid [`NUM_FU_ALU],
    input  backend_pkg::alu_op_t   alu_op    [`NUM_FU_ALU],
    input  backend_pkg::phys_tag_t alu_src1  [`NUM_FU_ALU],
    input  backend_pkg::phys_tag_t alu_src2  [`NUM_FU_ALU],
    input  backend_pkg::phys_tag_t alu_dest  [`NUM_FU_ALU],
    input  backend_pkg::data_t     alu_imm   [`NUM_FU_ALU],
    output logic                   alu_ready [`NUM_FU_ALU],

    // Multiplier issue
    input  logic                   mult_valid,
    input  backend_pkg::phys_tag_t mult_src1,
    input  backend_pkg::phys_tag_t mult_src2,
    input  backend_pkg::phys_tag_t mult_dest,
    output logic                   mult_ready,

    // Common data bus
    output logic                   cdb_valid [`CDB_SZ],
    output backend_pkg::phys_tag_t cdb_tag   [`CDB_SZ],
    output backend_pkg::data_t     cdb_data  [`CDB_SZ]
);

    localparam int MULT_IDX = `NUM_FU_ALU;

    backend_pkg::phys_tag_t rd_tag  [2*`NUM_FU];
    backend_pkg::data_t     rd_data [2*`NUM_FU];

    backend_pkg::fu_mask_t  fu_req;
    backend_pkg::fu_mask_t  fu_grant;
    backend_pkg::phys_tag_t fu_tag  [`NUM_FU];
    backend_pkg::data_t     fu_data [`NUM_FU];

    logic                   slot_valid [`CDB_SZ];
    backend_pkg::fu_idx_t   slot_owner [`CDB_SZ];

    // Read ports 2u and 2u+1 belong to unit u
    always_comb begin
        for (int u = 0; u < `NUM_FU_ALU; u++) begin
            rd_tag[2*u]   = alu_src1[u];
            rd_tag[2*u+1] = alu_src2[u];
        end
        rd_tag[2*MULT_IDX]   = mult_src1;
        rd_tag[2*MULT_IDX+1] = mult_src2;
    end

    phys_regfile regfile0 (
        .clock(clock), .reset(reset),
        .rd_tag(rd_tag), .rd_data(rd_data),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data)
    );

    alu_unit alu0 (
        .clock(clock), .reset(reset),
        .valid(alu_valid[0]), .op(alu_op[0]), .dest(alu_dest[0]), .imm(alu_imm[0]),
        .ready(alu_ready[0]), .opa(rd_data[0]), .opb(rd_data[1]),
        .req(fu_req[0]), .grant(fu_grant[0]), .res_tag(fu_tag[0]), .res_data(fu_data[0])
    );

    alu_unit alu1 (
        .clock(clock), .reset(reset),
        .valid(alu_valid[1]), .op(alu_op[1]), .dest(alu_dest[1]), .imm(alu_imm[1]),
        .ready(alu_ready[1]), .opa(rd_data[2]), .opb(rd_data[3]),
        .req(fu_req[1]), .grant(fu_grant[1]), .res_tag(fu_tag[1]), .res_data(fu_data[1])
    );

    mult_unit mult0 (
        .clock(clock), .reset(reset),
        .valid(mult_valid), .dest(mult_dest), .ready(mult_ready),
        .opa(rd_data[2*MULT_IDX]), .opb(rd_data[2*MULT_IDX+1]),
        .req(fu_req[MULT_IDX]), .grant(fu_grant[MULT_IDX]),
        .res_tag(fu_tag[MULT_IDX]), .res_data(fu_data[MULT_IDX])
    );

    cdb_arbiter arb0 (
        .clock(clock), .reset(reset),
        .req(fu_req), .grant(fu_grant),
        .slot_valid(slot_valid), .slot_owner(slot_owner)
    );

    // Steer each owner's result onto its slot
    always_comb begin
        for (int s = 0; s < `CDB_SZ; s++) begin
            cdb_valid[s] = slot_valid[s];
            cdb_tag[s]   = fu_tag[slot_owner[s]];
            cdb_data[s]  = fu_data[slot_owner[s]];
        end
    end

endmodule

//--- design/cdb_arbiter.sv
`include "backend_defines.svh"

module cdb_arbiter (
    input  logic                  clock,
    input  logic                  reset,

    input  backend_pkg::fu_mask_t req,
    output backend_pkg::fu_mask_t grant,

    // Per slot, whether it is used and which requester owns it
    output logic                  slot_valid [`CDB_SZ],
    output backend_pkg::fu_idx_t  slot_owner [`CDB_SZ]
);

    backend_pkg::fu_idx_t ptr;
    backend_pkg::fu_idx_t last_idx;
    backend_pkg::fu_idx_t next_ptr;

    // Walk the requesters starting at the pointer, one slot each
    always_comb begin
        int idx;
        int used;
        grant    = '0;
        used     = 0;
        last_idx = ptr;
        for (int s = 0; s < `CDB_SZ; s++) begin
            slot_valid[s] = 1'b0;
            slot_owner[s] = '0;
        end
        for (int i = 0; i < `NUM_FU; i++) begin
            idx = int'(ptr) + i;
            if (idx >= `NUM_FU) begin
                idx = idx - `NUM_FU;
            end
            if (req[idx] && (used < `CDB_SZ)) begin
                grant[idx]       = 1'b1;
                slot_valid[used] = 1'b1;
                slot_owner[used] = backend_pkg::fu_idx_t'(idx);
                last_idx         = backend_pkg::fu_idx_t'(idx);
                used             = used + 1;
            end
        end
    end

    // Next search starts just past the last winner
    assign next_ptr = (int'(last_idx) == `NUM_FU - 1) ? '0 : last_idx + 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            ptr <= '0;
        end else if (|grant) begin
            ptr <= next_ptr;
        end
    end

endmodule

//--- design/mult_unit.sv
`include "backend_defines.svh"

module mult_unit (
    input  logic                   clock,
    input  logic                   reset,

    // Issue
    input  logic                   valid,
    input  backend_pkg::phys_tag_t dest,
    output logic                   ready,

    // Operands from the register file
    input  backend_pkg::data_t     opa,
    input  backend_pkg::data_t     opb,

    // CDB request and result
    output logic                   req,
    input  logic                   grant,
    output backend_pkg::phys_tag_t res_tag,
    output backend_pkg::data_t     res_data
);

    localparam int NS    = `MULT_STAGES;
    // Bits of the multiplier consumed per stage
    localparam int CHUNK = (`DATA_W + NS - 1) / NS;

    logic                   stg_valid [NS];
    backend_pkg::phys_tag_t stg_tag   [NS];
    backend_pkg::data_t     stg_acc   [NS];
    // Operands only travel as far as the stage that consumes them last
    backend_pkg::data_t     stg_a     [NS-1];
    backend_pkg::data_t     stg_b     [NS-1];

    logic                   adv     [NS];
    backend_pkg::data_t     in_a    [NS];
    backend_pkg::data_t     in_b    [NS];
    backend_pkg::data_t     in_acc  [NS];
    backend_pkg::data_t     partial [NS];

    // Stage s moves when it is empty or the stage after it moves
    always_comb begin
        adv[NS-1] = !stg_valid[NS-1] || grant;
        for (int s = NS - 2; s >= 0; s--) begin
            adv[s] = !stg_valid[s] || adv[s+1];
        end
    end

    // Each stage adds one shifted partial product to the running sum
    always_comb begin
        backend_pkg::data_t chunk_mask;
        chunk_mask = backend_pkg::data_t'((64'd1 << CHUNK) - 64'd1);
        for (int s = 0; s < NS; s++) begin
            in_a[s]    = (s == 0) ? opa : stg_a[s-1];
            in_b[s]    = (s == 0) ? opb : stg_b[s-1];
            in_acc[s]  = (s == 0) ? '0  : stg_acc[s-1];
            partial[s] = (in_a[s] * ((in_b[s] >> (s * CHUNK)) & chunk_mask)) << (s * CHUNK);
        end
    end

    assign ready = adv[0];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < NS; s++) begin
                stg_valid[s] <= 1'b0;
            end
        end else begin
            for (int s = 0; s < NS; s++) begin
                if (adv[s]) begin
                    stg_valid[s] <= (s == 0) ? valid : stg_valid[s-1];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int s = 0; s < NS; s++) begin
            if (adv[s]) begin
                stg_tag[s] <= (s == 0) ? dest : stg_tag[s-1];
                stg_acc[s] <= in_acc[s] + partial[s];
            end
        end
        for (int s = 0; s < NS - 1; s++) begin
            if (adv[s]) begin
                stg_a[s] <= in_a[s];
                stg_b[s] <= in_b[s];
            end
        end
    end

    assign req      = stg_valid[NS-1];
    assign res_tag  = stg_tag[NS-1];
    assign res_data = stg_acc[NS-1];

endmodule

//--- design/alu_unit.sv
`include "backend_defines.svh"

module alu_unit (
    input  logic                   clock,
    input  logic                   reset,

    // Issue
    input  logic                   valid,
    input  backend_pkg::alu_op_t   op,
    input  backend_pkg::phys_tag_t dest,
    input  backend_pkg::data_t     imm,
    output logic                   ready,

    // Operands from the register file
    input  backend_pkg::data_t     opa,
    input  backend_pkg::data_t     opb,

    // CDB request and result
    output logic                   req,
    input  logic                   grant,
    output backend_pkg::phys_tag_t res_tag,
    output backend_pkg::data_t     res_data
);

    localparam int SHAMT_W = $clog2(`DATA_W);

    logic                   hold_valid;
    backend_pkg::phys_tag_t hold_tag;
    backend_pkg::data_t     hold_data;
    backend_pkg::data_t     result;
    logic                   accept;

    always_comb begin
        case (op)
            backend_pkg::ALU_ADD: result = opa + opb;
            backend_pkg::ALU_SUB: result = opa - opb;
            backend_pkg::ALU_AND: result = opa & opb;
            backend_pkg::ALU_OR:  result = opa | opb;
            backend_pkg::ALU_XOR: result = opa ^ opb;
            backend_pkg::ALU_SLL: result = opa << opb[SHAMT_W-1:0];
            backend_pkg::ALU_LI:  result = imm;
            default:              result = '0;
        endcase
    end

    // Buffer frees up in the same cycle it is granted
    assign ready  = !hold_valid || grant;
    assign accept = valid && ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            hold_valid <= 1'b0;
        end else if (accept) begin
            hold_valid <= 1'b1;
        end else if (grant) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            hold_tag  <= dest;
            hold_data <= result;
        end
    end

    assign req      = hold_valid;
    assign res_tag  = hold_tag;
    assign res_data = hold_data;

endmodule

//--- design/phys_regfile.sv
`include "backend_defines.svh"

module phys_regfile (
    input  logic                  clock,
    input  logic                  reset,

    // Two read ports per unit, src1 then src2
    input  backend_pkg::phys_tag_t rd_tag  [2*`NUM_FU],
    output backend_pkg::data_t     rd_data [2*`NUM_FU],

    // CDB write ports
    input  logic                  cdb_valid [`CDB_SZ],
    input  backend_pkg::phys_tag_t cdb_tag   [`CDB_SZ],
    input  backend_pkg::data_t     cdb_data  [`CDB_SZ]
);

    localparam int RD_PORTS = 2 * `NUM_FU;

    backend_pkg::data_t entries [`PHYS_REG_SZ];

    // Read ports
    // A matching CDB slot wins over storage, lowest slot first
    always_comb begin
        logic hit;
        for (int p = 0; p < RD_PORTS; p++) begin
            hit = 1'b0;
            rd_data[p] = '0;
            for (int s = 0; s < `CDB_SZ; s++) begin
                if (!hit && cdb_valid[s] && (cdb_tag[s] == rd_tag[p])
                        && (rd_tag[p] != '0)) begin
                    hit = 1'b1;
                    rd_data[p] = cdb_data[s];
                end
            end
            // Zero register reads as 0 regardless of any broadcast
            if (!hit && (rd_tag[p] != '0)) begin
                rd_data[p] = entries[rd_tag[p]];
            end
        end
    end

    // Every valid slot is written at the edge
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < `PHYS_REG_SZ; r++) begin
                entries[r] <= '0;
            end
        end else begin
            for (int s = 0; s < `CDB_SZ; s++) begin
                // Entry 0 is never written
                if (cdb_valid[s] && (cdb_tag[s] != '0)) begin
                    entries[cdb_tag[s]] <= cdb_data[s];
                end
            end
        end
    end

endmodule

//--- common/backend_pkg.sv
`include "backend_defines.svh"

package backend_pkg;

    // One data word
    typedef logic [`DATA_W-1:0] data_t;

    // Physical register tag, tag 0 is the hardwired zero register
    typedef logic [$clog2(`PHYS_REG_SZ)-1:0] phys_tag_t;

    // One bit per CDB requester
    typedef logic [`NUM_FU-1:0] fu_mask_t;

    // Index of a CDB requester
    typedef logic [$clog2(`NUM_FU)-1:0] fu_idx_t;

    // ALU operations
    // LI passes the immediate straight through
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_LI  = 3'd6
    } alu_op_t;

endpackage

//--- common/backend_defines.svh
`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

// Physical register file geometry
`define PHYS_REG_SZ 32
`define DATA_W 32

// Functional units
// Requester order on the CDB is ALU0, ALU1, MULT0
`define NUM_FU_ALU 2
`define NUM_FU_MULT 1
`define NUM_FU (`NUM_FU_ALU + `NUM_FU_MULT)

// Result broadcast slots per cycle
`define CDB_SZ 2

// Multiplier latency in registered stages
`define MULT_STAGES 3

`endif
